//--- verilog/hsi_cfg_pkg.sv
package hsi_cfg_pkg;

  // ======================================================================
  // mark rate
  // ======================================================================

  // one bit, selects the mark period.
  typedef enum logic
  {
    rate_1hz  = 1'b0,  // one mark per second.
    rate_10hz = 1'b1   // one mark per tenth of a second.
  } tm_rate_e;

  // ======================================================================
  // service codes, upper nibble of a service byte
  // ======================================================================

  typedef enum logic [3:0]
  {
    svc_sof     = 4'd1,  // start of control word.
    svc_dest    = 4'd2,  // destination address.
    svc_seq     = 4'd3,  // word sequence number.
    svc_tmstamp = 4'd4,  // tenth count at word start.
    svc_mark    = 4'd15  // time-mark frame only.
  } svc_code_e;

endpackage

//--- verilog/hsi_frame_pkg.sv
package hsi_frame_pkg;

  // ======================================================================
  // line word, one byte with two views
  // ======================================================================

  // service view: code in the upper nibble, argument in the lower.
  typedef struct packed
  {
    hsi_cfg_pkg::svc_code_e code;  // service code.
    logic [3:0]             arg;   // code argument.
  } svc_word_t;

  typedef union packed
  {
    logic [7:0] raw;  // data and crc bytes.
    svc_word_t  svc;  // service and mark bytes.
  } line_word_u;

  // ======================================================================
  // stream types
  // ======================================================================

  // host byte, carried on the req/ack port.
  typedef struct packed
  {
    logic [3:0] dest;  // destination of the control word.
    logic [7:0] data;  // data byte.
    logic       last;  // final data byte of the word.
  } host_byte_t;

  // builder to arbiter frame.
  typedef struct packed
  {
    line_word_u word;     // byte to put on the line.
    logic       is_mark;  // set for a time-mark frame.
  } frame_t;

endpackage

//--- verilog/tm_gen.sv
`timescale 1ns/1ps

module tm_gen #(
  parameter int                     clks_per_bit = 8,
  parameter int                     clks_per_sec = 50_000_000,
  parameter hsi_cfg_pkg::tm_rate_e  tm_rate      = hsi_cfg_pkg::rate_1hz,
  parameter int                     max_data     = 62
) (
  input  logic       clk,
  input  logic       n_rst,
  output logic       tm,
  output logic       pre_tm,
  output logic [3:0] tenth
);

  // ======================================================================
  // period and guard window
  // ======================================================================

  // mark period in clocks.
  localparam int period = (tm_rate == hsi_cfg_pkg::rate_1hz) ? clks_per_sec
                                                              : clks_per_sec / 10;
  localparam int frame_clks = 11 * clks_per_bit;                  // one 11-bit frame.
  localparam int guard      = (4 + max_data + 2 + 2) * frame_clks;  // longest word plus margin.
  localparam int pre_start  = period - 1 - guard;                 // first tick of the window.
  localparam int tick_w     = $clog2(period);

  logic [tick_w-1:0] ticks;      // free-running mark timer.
  logic [3:0]        tenth_q;    // decade counter.
  logic              decade_en;  // window allowed in this interval.
  logic              in_window;  // timer inside the guard window.

  // ======================================================================
  // mark timer
  // ======================================================================

  assign tm = (ticks == tick_w'(period - 1));  // last tick of the period.

  always_ff @(posedge clk or negedge n_rst)
  begin
    if (!n_rst)
      ticks <= '0;
    else if (tm)
      ticks <= '0;  // restart on the mark.
    else
      ticks <= ticks + 1'b1;
  end

  // decade count, advances on every mark.
  always_ff @(posedge clk or negedge n_rst)
  begin
    if (!n_rst)
      tenth_q <= 4'd0;
    else if (tm)
      tenth_q <= (tenth_q == 4'd9) ? 4'd0 : tenth_q + 4'd1;  // wrap 9 -> 0.
  end

  assign tenth = tenth_q;

  // ======================================================================
  // pre-mark window
  // ======================================================================

  // at 10 hz only the interval that ends in the rollover gets a window.
  assign decade_en = (tm_rate == hsi_cfg_pkg::rate_1hz) || (tenth_q == 4'd9);
  assign in_window = (ticks >= tick_w'(pre_start));

  // drops on the mark itself.
  assign pre_tm = decade_en & in_window & ~tm;

endmodule

//--- verilog/ccw_builder.sv
`timescale 1ns/1ps

module ccw_builder (
  input  logic                     clk,
  input  logic                     n_rst,
  input  logic                     host_req,
  input  hsi_frame_pkg::host_byte_t host_byte,
  output logic                     host_ack,
  input  logic                     pre_tm,
  input  logic                     tm,
  input  logic [3:0]               tenth,
  output hsi_frame_pkg::frame_t    ccw_frame,
  output logic                     ccw_valid,
  input  logic                     ccw_ready
);

  typedef enum logic [2:0]
  {
    st_idle,    // waiting for a host request.
    st_svc,     // four service bytes.
    st_data,    // host data bytes.
    st_crc_hi,  // crc high byte.
    st_crc_lo   // crc low byte.
  } state_e;

  state_e                    state;
  logic [1:0]                svc_idx;    // service byte on the stream.
  logic [1:0]                next_idx;   // service byte to load next.
  logic [3:0]                seq_q;      // word sequence number.
  logic [3:0]                dest_q;     // destination of the word.
  logic [3:0]                stamp_q;    // tenth count at word start.
  logic [15:0]               crc_q;      // running crc.
  logic                      last_q;     // frame holds the last data byte.
  logic                      accept;     // frame taken by the arbiter.
  logic                      host_new;   // host byte not yet acked.
  logic                      word_go;    // start a control word.
  logic                      load;       // load the output frame.
  hsi_frame_pkg::line_word_u svc_word;   // next service byte.
  hsi_frame_pkg::line_word_u next_word;  // next byte for the frame.

  // crc-16-ccitt, one byte, msb first.
  function automatic logic [15:0] crc16_byte(input logic [15:0] crc, input logic [7:0] d);
    logic [15:0] c;
    logic        fb;
    c = crc;
    for (int i = 7; i >= 0; i--)
    begin
      fb = c[15] ^ d[i];
      c  = {c[14:0], 1'b0};
      if (fb)
        c = c ^ 16'h1021;
    end
    return c;
  endfunction

  assign accept   = ccw_valid & ccw_ready;
  assign host_new = host_req & ~host_ack;
  assign word_go  = host_new & ~pre_tm & ~tm;  // no new word near a mark.
  assign next_idx = (state == st_idle) ? 2'd0 : svc_idx + 2'd1;

  // ======================================================================
  // next frame
  // ======================================================================

  always_comb
  begin
    case (next_idx)
      2'd0:    svc_word.svc = '{code: hsi_cfg_pkg::svc_sof,     arg: 4'd0};
      2'd1:    svc_word.svc = '{code: hsi_cfg_pkg::svc_dest,    arg: dest_q};
      2'd2:    svc_word.svc = '{code: hsi_cfg_pkg::svc_seq,     arg: seq_q};
      default: svc_word.svc = '{code: hsi_cfg_pkg::svc_tmstamp, arg: stamp_q};
    endcase
  end

  always_comb
  begin
    load      = 1'b0;
    next_word = svc_word;
    case (state)
      st_idle:   load = word_go;
      st_svc:    load = accept && (svc_idx != 2'd3);
      st_data:
      begin
        load          = host_new && !ccw_valid;  // one frame per handshake.
        next_word.raw = host_byte.data;
      end
      st_crc_hi:
      begin
        load          = !ccw_valid;
        next_word.raw = crc_q[15:8];
      end
      default:
      begin
        load          = !ccw_valid;
        next_word.raw = crc_q[7:0];
      end
    endcase
  end

  // ======================================================================
  // sequencer and host handshake
  // ======================================================================

  always_ff @(posedge clk or negedge n_rst)
  begin
    if (!n_rst)
    begin
      state     <= st_idle;
      svc_idx   <= 2'd0;
      seq_q     <= 4'd0;
      host_ack  <= 1'b0;
      ccw_valid <= 1'b0;
    end
    else
    begin
      if (load)
        ccw_valid <= 1'b1;
      else if (accept)
        ccw_valid <= 1'b0;
      if (host_ack && !host_req)
        host_ack <= 1'b0;  // phase 4.
      case (state)
        st_idle:
          if (word_go)
          begin
            state   <= st_svc;
            svc_idx <= 2'd0;
          end
        st_svc:
          if (accept)
          begin
            svc_idx <= svc_idx + 2'd1;
            if (svc_idx == 2'd3)
              state <= st_data;
          end
        st_data:
          if (accept)
          begin
            host_ack <= 1'b1;  // phase 2, byte is on its way.
            if (last_q)
              state <= st_crc_hi;
          end
        st_crc_hi:
          if (accept)
            state <= st_crc_lo;
        default:
          if (accept)
          begin
            state <= st_idle;
            seq_q <= seq_q + 4'd1;  // next word number.
          end
      endcase
    end
  end

  // frame contents and word fields.
  always_ff @(posedge clk)
  begin
    if (load)
    begin
      ccw_frame.word    <= next_word;
      ccw_frame.is_mark <= 1'b0;
    end
    if (load && state == st_data)
      last_q <= host_byte.last;
    if (word_go && state == st_idle)
    begin
      dest_q  <= host_byte.dest;
      stamp_q <= tenth;
      crc_q   <= 16'hffff;
    end
    else if (accept && (state == st_svc || state == st_data))
      crc_q <= crc16_byte(crc_q, ccw_frame.word.raw);  // crc bytes are not covered.
  end

endmodule

//--- verilog/frame_ser.sv
`timescale 1ns/1ps

module frame_ser #(
  parameter int clks_per_bit = 8
) (
  input  logic       clk,
  input  logic       n_rst,
  input  logic       start,
  input  logic [7:0] byte_in,
  output logic       busy,
  output logic       tx
);

  localparam int cnt_w = (clks_per_bit > 1) ? $clog2(clks_per_bit) : 1;

  logic [10:0]      shreg;    // frame bits, lsb on the line.
  logic [cnt_w-1:0] clk_cnt;  // clocks within the bit.
  logic [3:0]       bit_cnt;  // bit index, 0 to 10.
  logic             active;   // frame in progress.
  logic             bit_end;  // last clock of the bit.

  assign bit_end = (clk_cnt == cnt_w'(clks_per_bit - 1));

  // ======================================================================
  // bit timing and shift
  // ======================================================================

  always_ff @(posedge clk or negedge n_rst)
  begin
    if (!n_rst)
    begin
      shreg   <= '1;  // line idles high.
      clk_cnt <= '0;
      bit_cnt <= 4'd0;
      active  <= 1'b0;
    end
    else if (start && !active)
    begin
      // stop, odd parity, data lsb first, start.
      shreg   <= {1'b1, ~^byte_in, byte_in, 1'b0};
      clk_cnt <= '0;
      bit_cnt <= 4'd0;
      active  <= 1'b1;
    end
    else if (active)
    begin
      if (bit_end)
      begin
        clk_cnt <= '0;
        shreg   <= {1'b1, shreg[10:1]};  // shift in idle ones.
        if (bit_cnt == 4'd10)
          active <= 1'b0;  // stop bit done.
        else
          bit_cnt <= bit_cnt + 4'd1;
      end
      else
        clk_cnt <= clk_cnt + 1'b1;
    end
  end

  assign busy = active;
  assign tx   = shreg[0];

endmodule

//--- verilog/line_arbiter.sv
`timescale 1ns/1ps

module line_arbiter #(
  parameter int clks_per_bit = 8
) (
  input  logic                  clk,
  input  logic                  n_rst,
  input  logic                  tm,
  input  logic [3:0]            tenth,
  input  hsi_frame_pkg::frame_t ccw_frame,
  input  logic                  ccw_valid,
  output logic                  ccw_ready,
  output logic                  tx
);

  logic                      mark_pend;  // mark waiting for the line.
  logic                      ser_busy;   // serializer sending.
  logic                      ser_start;  // serializer load pulse.
  hsi_frame_pkg::line_word_u mark_word;  // mark byte.
  hsi_frame_pkg::frame_t     sel_frame;  // frame granted this cycle.

  // ======================================================================
  // mark frame
  // ======================================================================

  // code 15, argument is the current tenth count.
  always_comb
  begin
    mark_word.svc.code = hsi_cfg_pkg::svc_mark;
    mark_word.svc.arg  = tenth;
  end

  // held from the mark until its frame goes out.
  always_ff @(posedge clk or negedge n_rst)
  begin
    if (!n_rst)
      mark_pend <= 1'b0;
    else if (tm)
      mark_pend <= 1'b1;
    else if (ser_start && sel_frame.is_mark)
      mark_pend <= 1'b0;
  end

  // ======================================================================
  // grant
  // ======================================================================

  always_comb
  begin
    if (mark_pend)
    begin
      sel_frame.word    = mark_word;  // mark wins.
      sel_frame.is_mark = 1'b1;
    end
    else
      sel_frame = ccw_frame;
  end

  // back-pressure while sending or while a mark waits.
  assign ccw_ready = ~ser_busy & ~mark_pend;
  assign ser_start = ~ser_busy & (mark_pend | ccw_valid);

  frame_ser #(
    .clks_per_bit(clks_per_bit)
  ) ser0 (
    .clk     (clk),
    .n_rst   (n_rst),
    .start   (ser_start),
    .byte_in (sel_frame.word.raw),
    .busy    (ser_busy),
    .tx      (tx)
  );

endmodule

//--- verilog/hsi_master_top.sv
`timescale 1ns/1ps

module hsi_master_top #(
  parameter int                    clks_per_bit = 8,
  parameter int                    clks_per_sec = 50_000_000,
  parameter hsi_cfg_pkg::tm_rate_e tm_rate      = hsi_cfg_pkg::rate_1hz,
  parameter int                    max_data     = 62
) (
  input  logic                      clk,
  input  logic                      n_rst,
  input  logic                      host_req,
  input  hsi_frame_pkg::host_byte_t host_byte,
  output logic                      host_ack,
  output logic                      tm,
  output logic                      pre_tm,
  output logic                      tx
);

  logic [3:0]            tenth;      // decade count from the mark timer.
  hsi_frame_pkg::frame_t ccw_frame;  // builder stream.
  logic                  ccw_valid;
  logic                  ccw_ready;

  // ======================================================================
  // time mark
  // ======================================================================

  tm_gen #(
    .clks_per_bit (clks_per_bit),
    .clks_per_sec (clks_per_sec),
    .tm_rate      (tm_rate),
    .max_data     (max_data)
  ) tm0 (
    .clk    (clk),
    .n_rst  (n_rst),
    .tm     (tm),
    .pre_tm (pre_tm),
    .tenth  (tenth)
  );

  // ======================================================================
  // control words and line
  // ======================================================================

  ccw_builder bld0 (
    .clk       (clk),
    .n_rst     (n_rst),
    .host_req  (host_req),
    .host_byte (host_byte),
    .host_ack  (host_ack),
    .pre_tm    (pre_tm),
    .tm        (tm),
    .tenth     (tenth),
    .ccw_frame (ccw_frame),
    .ccw_valid (ccw_valid),
    .ccw_ready (ccw_ready)
  );

  line_arbiter #(
    .clks_per_bit (clks_per_bit)
  ) arb0 (
    .clk       (clk),
    .n_rst     (n_rst),
    .tm        (tm),
    .tenth     (tenth),
    .ccw_frame (ccw_frame),
    .ccw_valid (ccw_valid),
    .ccw_ready (ccw_ready),
    .tx        (tx)
  );

endmodule

//--- test/hsi_master_chk.sv
`timescale 1ns/1ps

module hsi_master_chk (
  input logic clk,
  input logic n_rst,
  input logic host_req,
  input logic host_ack,
  input logic tm,
  input logic tx,
  input logic ser_busy
);

  // ======================================================================
  // host handshake
  // ======================================================================

  ack_needs_req: assert property (@(posedge clk) disable iff (!n_rst)
    $rose(host_ack) |-> host_req)
    else $error("host_ack rose while host_req was low");  // phase 2 only after phase 1.

  req_held: assert property (@(posedge clk) disable iff (!n_rst)
    (host_req && !host_ack) |=> host_req)
    else $error("host_req dropped before host_ack");  // request held until acked.

  // ======================================================================
  // mark and line
  // ======================================================================

  tm_one_cycle: assert property (@(posedge clk) disable iff (!n_rst)
    tm |=> !tm)
    else $error("tm pulse longer than one cycle");

  idle_high: assert property (@(posedge clk) disable iff (!n_rst)
    !ser_busy |-> tx)
    else $error("tx low while the serializer is idle");

endmodule

bind hsi_master_top hsi_master_chk chk0 (
  .clk      (clk),
  .n_rst    (n_rst),
  .host_req (host_req),
  .host_ack (host_ack),
  .tm       (tm),
  .tx       (tx),
  .ser_busy (arb0.ser_busy)
);

//--- test/hsi_master_tb.sv
`timescale 1ns/1ps

module hsi_master_tb;

  localparam int period  = 6000;  // 60000 / 10 clocks.
  localparam int guard   = 704;   // 16 frames of 44 clocks.
  localparam int n_words = 7;

  logic                      clk;
  logic                      n_rst;
  logic                      host_req;
  hsi_frame_pkg::host_byte_t host_byte;
  logic                      host_ack;
  logic                      tm;
  logic                      pre_tm;
  logic                      tx;

  // stimulus table with request cycle, dest, length, expected stamp and window flag.
  int         t_cyc   [n_words] = '{100, 900, 6100, 12500, 29000, 59500, 61500};
  logic [3:0] t_dest  [n_words] = '{4'd3, 4'd10, 4'd1, 4'd15, 4'd6, 4'd9, 4'd12};
  int         t_len   [n_words] = '{3, 8, 1, 5, 8, 4, 2};
  logic [3:0] t_stamp [n_words] = '{4'd0, 4'd0, 4'd1, 4'd2, 4'd4, 4'd0, 4'd0};
  logic       t_win   [n_words] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0};

  int         cyc         = 0;  // clock count advanced on posedge.
  int         tm_count    = 0;  // marks seen on tm.
  int         last_tm_cyc = 0;  // cycle of the latest tm.
  int         marks_sent  = 0;  // mark frames decoded on tx.
  int         ack_count   = 0;  // host_ack rising edges.
  logic [3:0] last_arg    = 4'd0;  // argument of the latest mark frame.
  logic [7:0] rx_q   [$];  // decoded control-word bytes.
  logic [3:0] mark_q [$];  // last mark argument at each byte.

  hsi_master_top #(
    .clks_per_bit (4),
    .clks_per_sec (60000),
    .tm_rate      (hsi_cfg_pkg::rate_10hz),
    .max_data     (8)
  ) dut0 (
    .clk       (clk),
    .n_rst     (n_rst),
    .host_req  (host_req),
    .host_byte (host_byte),
    .host_ack  (host_ack),
    .tm        (tm),
    .pre_tm    (pre_tm),
    .tx        (tx)
  );

  always #2 clk = ~clk;  // 4 ns period.

  always @(posedge clk)
    cyc <= cyc + 1;  // stable at negedge.

  // ======================================================================
  // error handling and reference model
  // ======================================================================

  task automatic abort_run();
    $display("TESTS FAILED");
    $fatal(1);
  endtask

  task automatic report_fault(input string msg);
    $display("%s", msg);
    abort_run();
  endtask

  task automatic check_value(input string name, input int exp, input int act);
    assert (exp == act)
    else
    begin
      $display("[ERROR] %s expected 0x%0h actual 0x%0h", name, exp, act);
      abort_run();
    end
  endtask

  // crc-16-ccitt with the byte folded into the high half.
  function automatic logic [15:0] crc_ccitt(input logic [15:0] crc, input logic [7:0] b);
    logic [15:0] r;
    r = crc ^ {b, 8'h00};
    repeat (8)
      r = r[15] ? ((r << 1) ^ 16'h1021) : (r << 1);
    return r;
  endfunction

  // ======================================================================
  // host driver and waits
  // ======================================================================

  task automatic wait_cycle(input int target);
    int n;
    for (n = 0; n < 70000 && cyc < target; n++)
      @(negedge clk);
    assert (cyc >= target) else report_fault("request cycle never reached");
  endtask

  task automatic send_byte(input logic [3:0] d, input logic [7:0] x, input logic l);
    int n;
    @(posedge clk);
    host_byte <= '{dest: d, data: x, last: l};  // phase 1.
    host_req  <= 1'b1;
    for (n = 0; n < 4000 && !host_ack; n++)
      @(negedge clk);
    assert (host_ack) else report_fault("host_ack never rose");
    @(posedge clk);
    host_req <= 1'b0;  // phase 3.
    for (n = 0; n < 100 && host_ack; n++)
      @(negedge clk);
    assert (!host_ack) else report_fault("host_ack never dropped");
  endtask

  // ======================================================================
  // monitors
  // ======================================================================

  // mark timing, pre_tm window and ack count.
  initial
  begin : mark_monitor
    logic exp_pre;
    logic ack_d;
    ack_d = 1'b0;
    forever
    begin
      @(negedge clk);
      if (n_rst)
      begin
        exp_pre = (tm_count % 10 == 9) && (cyc >= last_tm_cyc + period - guard)
                  && (cyc < last_tm_cyc + period);  // window before the rollover.
        check_value($sformatf("pre_tm at cycle %0d", cyc), int'(exp_pre), int'(pre_tm));
        if (tm)
        begin
          if (tm_count > 0)
            check_value("tm period", last_tm_cyc + period, cyc);
          tm_count++;
          last_tm_cyc = cyc;
        end
        if (host_ack && !ack_d)
          ack_count++;
        ack_d = host_ack;
      end
    end
  end

  // mid-bit sampling of tx into frames.
  initial
  begin : line_decoder
    logic [10:0] bits;
    int          c0;
    int          pending;
    forever
    begin
      @(negedge clk);
      if (n_rst && tx === 1'b0)
      begin
        c0      = cyc;
        pending = (c0 > last_tm_cyc + 1) ? tm_count : tm_count - 1;  // marks due now.
        repeat (2) @(negedge clk);
        bits[0] = tx;
        for (int i = 1; i < 11; i++)
        begin
          repeat (4) @(negedge clk);
          bits[i] = tx;
        end
        check_value("start bit", 0, int'(bits[0]));
        check_value("stop bit", 1, int'(bits[10]));
        check_value("odd parity", 1, int'(^bits[9:1]));
        if (pending > marks_sent)
        begin
          marks_sent++;
          last_arg = 4'(marks_sent % 10);  // tenth after this mark.
          check_value($sformatf("mark %0d", marks_sent), int'({4'hf, last_arg}),
                      int'(bits[8:1]));
        end
        else
        begin
          rx_q.push_back(bits[8:1]);
          mark_q.push_back(last_arg);
        end
      end
    end
  end

  // ======================================================================
  // stimulus and word checks
  // ======================================================================

  initial
  begin : main_seq
    logic [7:0]  data [8];
    logic [7:0]  exp  [16];
    logic [15:0] crc;
    int          n;
    int          len;
    int          total;
    void'($urandom(14));
    clk       = 1'b0;
    n_rst     = 1'b0;
    host_req  = 1'b0;
    host_byte = '0;
    total     = 0;
    repeat (2) @(posedge clk);
    n_rst <= 1'b1;
    for (n = 0; n < 50; n++)
    begin
      @(negedge clk);
      assert (tx && !host_ack && !tm && !pre_tm)
      else report_fault("outputs left their reset values");
    end
    for (int w = 0; w < n_words; w++)
    begin
      len = t_len[w];
      for (int b = 0; b < len; b++)
        data[b] = 8'($urandom);
      wait_cycle(t_cyc[w]);
      if (t_win[w])
      begin
        assert (pre_tm) else report_fault("request missed the pre_tm window");
      end
      for (int b = 0; b < len; b++)
        send_byte(t_dest[w], data[b], b == len - 1);
      total += len;
      for (n = 0; n < 8000 && rx_q.size() < len + 6; n++)
        @(negedge clk);
      assert (rx_q.size() >= len + 6) else report_fault("control word never left the line");
      exp[0] = {4'h1, 4'h0};  // sof.
      exp[1] = {4'h2, t_dest[w]};
      exp[2] = {4'h3, 4'(w)};  // seq counts from 0.
      exp[3] = {4'h4, t_stamp[w]};
      for (int b = 0; b < len; b++)
        exp[4 + b] = data[b];
      crc = 16'hffff;
      for (int b = 0; b < len + 4; b++)
        crc = crc_ccitt(crc, exp[b]);
      exp[len + 4] = crc[15:8];
      exp[len + 5] = crc[7:0];
      check_value($sformatf("word %0d stamp vs line mark", w), int'(t_stamp[w]),
                  int'(mark_q[0]));
      for (int b = 0; b < len + 6; b++)
      begin
        check_value($sformatf("word %0d byte %0d", w, b), int'(exp[b]), int'(rx_q[0]));
        void'(rx_q.pop_front());
        void'(mark_q.pop_front());
      end
    end
    check_value("host ack count", total, ack_count);
    check_value("mark frames on the line", tm_count, marks_sent);  // one frame per tm.
    $display("TESTS PASSED");
    $finish;
  end

endmodule

//--- sources.f
verilog/hsi_cfg_pkg.sv
verilog/hsi_frame_pkg.sv
verilog/tm_gen.sv
verilog/ccw_builder.sv
verilog/frame_ser.sv
verilog/line_arbiter.sv
verilog/hsi_master_top.sv
test/hsi_master_chk.sv
test/hsi_master_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= hsi_master_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
